//--- common/exu_config.svh
/* Execute unit configuration.
   Data path width, CSR address width and the CSR address map. */

`ifndef EXU_CONFIG_SVH
`define EXU_CONFIG_SVH

// Integer data path width.
`define EXU_XLEN 64

// CSR address width, as in the CSR instruction encoding.
`define EXU_CSR_AW 12

// Implemented machine-mode CSRs.
`define EXU_CSR_MSTATUS  12'h300
`define EXU_CSR_MSCRATCH 12'h340
`define EXU_CSR_MEPC     12'h341
`define EXU_CSR_MCYCLE   12'hB00

`endif

//--- common/exu_pkg.sv
/* Execute unit types.
   Collapsed operation codes from decode and the CSR operation kinds. */

package exu_pkg;

  // Register and immediate forms share one code.
  typedef enum logic [7:0] {
    OP_NOP   = 8'd0,
    OP_ADD   = 8'd1,
    OP_SUB   = 8'd2,
    OP_ADDW  = 8'd3,
    OP_SUBW  = 8'd4,
    OP_AND   = 8'd5,
    OP_OR    = 8'd6,
    OP_XOR   = 8'd7,
    OP_SLL   = 8'd8,
    OP_SRL   = 8'd9,
    OP_SRA   = 8'd10,
    OP_SLLW  = 8'd11,
    OP_SRLW  = 8'd12,
    OP_SRAW  = 8'd13,
    OP_SLT   = 8'd14,
    OP_SLTU  = 8'd15,
    OP_LUI   = 8'd16,
    OP_AUIPC = 8'd17,
    OP_JAL   = 8'd18,
    OP_JALR  = 8'd19,
    OP_BEQ   = 8'd20,
    OP_BNE   = 8'd21,
    OP_BLT   = 8'd22,
    OP_BGE   = 8'd23,
    OP_BLTU  = 8'd24,
    OP_BGEU  = 8'd25,
    OP_CSRRW = 8'd26,
    OP_CSRRS = 8'd27,
    OP_CSRRC = 8'd28
  } opcode_e;

  // Read-modify-write applied to the addressed CSR.
  typedef enum logic [1:0] {
    CSR_NONE  = 2'd0,
    CSR_WRITE = 2'd1,
    CSR_SET   = 2'd2,
    CSR_CLEAR = 2'd3
  } csr_op_e;

endpackage

//--- csr_file/csr_file.sv
/* CSR file.
   Holds the machine CSRs, serves CSR instructions and a host APB port. */

`timescale 1ns/1ps
`include "exu_config.svh"

module csr_file
  import exu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_csr_wen,
  input  csr_op_e                i_csr_op,
  input  logic [`EXU_CSR_AW-1:0] i_csr_addr,
  input  logic [`EXU_XLEN-1:0]   i_csr_operand,
  output logic [`EXU_XLEN-1:0]   o_csr_rdata,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`EXU_CSR_AW-1:0] i_paddr,
  input  logic [`EXU_XLEN-1:0]   i_pwdata,
  output logic [`EXU_XLEN-1:0]   o_prdata,
  output logic                   o_pready
);

  logic [`EXU_XLEN-1:0]   mstatus;
  logic [`EXU_XLEN-1:0]   mscratch;
  logic [`EXU_XLEN-1:0]   mepc;
  logic [`EXU_XLEN-1:0]   mcycle;
  logic                   inst_wr;
  logic                   host_wr;
  logic                   wr_en;
  logic [`EXU_CSR_AW-1:0] wr_addr;
  logic [`EXU_XLEN-1:0]   wr_data;
  logic [`EXU_XLEN-1:0]   inst_wdata;

  always_comb begin
    case (i_csr_addr)
      `EXU_CSR_MSTATUS:  o_csr_rdata = mstatus;
      `EXU_CSR_MSCRATCH: o_csr_rdata = mscratch;
      `EXU_CSR_MEPC:     o_csr_rdata = mepc;
      `EXU_CSR_MCYCLE:   o_csr_rdata = mcycle;
      default:           o_csr_rdata = '0;
    endcase
  end

  always_comb begin
    case (i_paddr)
      `EXU_CSR_MSTATUS:  o_prdata = mstatus;
      `EXU_CSR_MSCRATCH: o_prdata = mscratch;
      `EXU_CSR_MEPC:     o_prdata = mepc;
      `EXU_CSR_MCYCLE:   o_prdata = mcycle;
      default:           o_prdata = '0;
    endcase
  end

  always_comb begin
    case (i_csr_op)
      CSR_WRITE: inst_wdata = i_csr_operand;
      CSR_SET:   inst_wdata = o_csr_rdata | i_csr_operand;
      CSR_CLEAR: inst_wdata = o_csr_rdata & ~i_csr_operand;
      default:   inst_wdata = o_csr_rdata;
    endcase
  end

  // A set or clear with an empty mask leaves the CSR alone, so mcycle keeps counting.
  assign inst_wr = i_csr_wen &&
                   (i_csr_op == CSR_WRITE || (i_csr_op != CSR_NONE && |i_csr_operand));

  // The instruction path wins; the host sees a wait state and writes next cycle.
  assign o_pready = i_psel && i_penable && !inst_wr;
  assign host_wr  = o_pready && i_pwrite;

  assign wr_en   = inst_wr || host_wr;
  assign wr_addr = inst_wr ? i_csr_addr : i_paddr;
  assign wr_data = inst_wr ? inst_wdata : i_pwdata;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      mstatus  <= '0;
      mscratch <= '0;
      mepc     <= '0;
      mcycle   <= '0;
    end else begin
      mcycle <= mcycle + 1'b1;
      if (wr_en) begin
        case (wr_addr)
          `EXU_CSR_MSTATUS:  mstatus  <= wr_data;
          `EXU_CSR_MSCRATCH: mscratch <= wr_data;
          `EXU_CSR_MEPC:     mepc     <= wr_data;
          `EXU_CSR_MCYCLE:   mcycle   <= wr_data;
          default:           ;
        endcase
      end
    end
  end

  // Completion needs a setup phase before the access phase.
  a_pready_access: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_pready |-> $past(i_psel));

endmodule

//--- design/branch_unit.sv
/* Branch unit.
   Resolves branch compares and selects the jump target. */

`timescale 1ns/1ps
`include "exu_config.svh"

module branch_unit
  import exu_pkg::*;
(
  input  opcode_e              i_opcode,
  input  logic [`EXU_XLEN-1:0] i_op1,
  input  logic [`EXU_XLEN-1:0] i_op2,
  input  logic [`EXU_XLEN-1:0] i_op3,
  output logic                 o_take,
  output logic [`EXU_XLEN-1:0] o_target
);

  logic                 eq;
  logic                 lt;
  logic                 ltu;
  logic [`EXU_XLEN-1:0] jalr_sum;

  assign eq       = i_op1 == i_op2;
  assign lt       = $signed(i_op1) < $signed(i_op2);
  assign ltu      = i_op1 < i_op2;
  assign jalr_sum = i_op1 + i_op2;

  always_comb begin
    o_take   = 1'b0;
    o_target = i_op3;
    case (i_opcode)
      OP_BEQ:  o_take = eq;
      OP_BNE:  o_take = !eq;
      OP_BLT:  o_take = lt;
      OP_BGE:  o_take = !lt;
      OP_BLTU: o_take = ltu;
      OP_BGEU: o_take = !ltu;
      OP_JAL:  o_take = 1'b1;
      OP_JALR: begin
        o_take   = 1'b1;
        o_target = {jalr_sum[`EXU_XLEN-1:1], 1'b0};
      end
      default: o_target = '0;
    endcase
  end

  // Decode must hand over halfword-aligned branch and JAL targets.
  a_target_aligned: assert #0 (!o_take || !o_target[0])
    else $error("taken target 0x%0h is odd", o_target);

endmodule

//--- design/exu_top.sv
/* Execute stage top level.
   Connects the ALU, branch unit, CSR file and writeback stage. */

`timescale 1ns/1ps
`include "exu_config.svh"

module exu_top
  import exu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_valid,
  input  opcode_e                i_opcode,
  input  logic [`EXU_XLEN-1:0]   i_op1,
  input  logic [`EXU_XLEN-1:0]   i_op2,
  input  logic [`EXU_XLEN-1:0]   i_op3,
  output logic                   o_wb_valid,
  output logic [`EXU_XLEN-1:0]   o_rd_wdata,
  output logic                   o_pc_jmp,
  output logic [`EXU_XLEN-1:0]   o_pc_jmpaddr,
  output logic                   o_skip_cmt,
  input  logic                   i_psel,
  input  logic                   i_penable,
  input  logic                   i_pwrite,
  input  logic [`EXU_CSR_AW-1:0] i_paddr,
  input  logic [`EXU_XLEN-1:0]   i_pwdata,
  output logic [`EXU_XLEN-1:0]   o_prdata,
  output logic                   o_pready
);

  logic [`EXU_XLEN-1:0]   alu_result;
  logic                   br_take;
  logic [`EXU_XLEN-1:0]   br_target;
  logic                   csr_wen;
  csr_op_e                csr_op;
  logic [`EXU_CSR_AW-1:0] csr_addr;
  logic [`EXU_XLEN-1:0]   csr_operand;
  logic [`EXU_XLEN-1:0]   csr_rdata;

  int_alu int_alu_inst (
    .i_opcode (i_opcode),
    .i_op1    (i_op1),
    .i_op2    (i_op2),
    .i_op3    (i_op3),
    .o_result (alu_result)
  );

  branch_unit branch_unit_inst (
    .i_opcode (i_opcode),
    .i_op1    (i_op1),
    .i_op2    (i_op2),
    .i_op3    (i_op3),
    .o_take   (br_take),
    .o_target (br_target)
  );

  csr_file csr_file_inst (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_csr_wen     (csr_wen),
    .i_csr_op      (csr_op),
    .i_csr_addr    (csr_addr),
    .i_csr_operand (csr_operand),
    .o_csr_rdata   (csr_rdata),
    .i_psel        (i_psel),
    .i_penable     (i_penable),
    .i_pwrite      (i_pwrite),
    .i_paddr       (i_paddr),
    .i_pwdata      (i_pwdata),
    .o_prdata      (o_prdata),
    .o_pready      (o_pready)
  );

  exu_writeback exu_writeback_inst (
    .i_clk         (i_clk),
    .i_rst_n       (i_rst_n),
    .i_valid       (i_valid),
    .i_opcode      (i_opcode),
    .i_op1         (i_op1),
    .i_op2         (i_op2),
    .i_alu_result  (alu_result),
    .i_take        (br_take),
    .i_target      (br_target),
    .i_csr_rdata   (csr_rdata),
    .o_csr_wen     (csr_wen),
    .o_csr_op      (csr_op),
    .o_csr_addr    (csr_addr),
    .o_csr_operand (csr_operand),
    .o_wb_valid    (o_wb_valid),
    .o_rd_wdata    (o_rd_wdata),
    .o_pc_jmp      (o_pc_jmp),
    .o_pc_jmpaddr  (o_pc_jmpaddr),
    .o_skip_cmt    (o_skip_cmt)
  );

endmodule

//--- design/exu_writeback.sv
/* Execute writeback stage.
   Drives CSR accesses and registers the result, jump and skip-commit flags. */

`timescale 1ns/1ps
`include "exu_config.svh"

module exu_writeback
  import exu_pkg::*;
(
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic                   i_valid,
  input  opcode_e                i_opcode,
  input  logic [`EXU_XLEN-1:0]   i_op1,
  input  logic [`EXU_XLEN-1:0]   i_op2,
  input  logic [`EXU_XLEN-1:0]   i_alu_result,
  input  logic                   i_take,
  input  logic [`EXU_XLEN-1:0]   i_target,
  input  logic [`EXU_XLEN-1:0]   i_csr_rdata,
  output logic                   o_csr_wen,
  output csr_op_e                o_csr_op,
  output logic [`EXU_CSR_AW-1:0] o_csr_addr,
  output logic [`EXU_XLEN-1:0]   o_csr_operand,
  output logic                   o_wb_valid,
  output logic [`EXU_XLEN-1:0]   o_rd_wdata,
  output logic                   o_pc_jmp,
  output logic [`EXU_XLEN-1:0]   o_pc_jmpaddr,
  output logic                   o_skip_cmt
);

  logic                 is_csr;
  logic [`EXU_XLEN-1:0] rd_next;

  always_comb begin
    case (i_opcode)
      OP_CSRRW: o_csr_op = CSR_WRITE;
      OP_CSRRS: o_csr_op = CSR_SET;
      OP_CSRRC: o_csr_op = CSR_CLEAR;
      default:  o_csr_op = CSR_NONE;
    endcase
  end

  assign is_csr        = o_csr_op != CSR_NONE;
  assign o_csr_wen     = i_valid && is_csr;
  assign o_csr_addr    = i_op2[`EXU_CSR_AW-1:0];
  assign o_csr_operand = i_op1;

  // An idle slot captures a NOP result.
  assign rd_next = !i_valid ? '0 : (is_csr ? i_csr_rdata : i_alu_result);

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_wb_valid <= 1'b0;
      o_pc_jmp   <= 1'b0;
      o_skip_cmt <= 1'b0;
    end else begin
      o_wb_valid <= i_valid;
      o_pc_jmp   <= i_valid && i_take;
      // The mcycle value read here is stale by commit, so commit skips it.
      o_skip_cmt <= o_csr_wen && (o_csr_addr == `EXU_CSR_MCYCLE);
    end
  end

  always_ff @(posedge i_clk) begin
    o_rd_wdata <= rd_next;
    if (i_valid) begin
      o_pc_jmpaddr <= i_target;
    end
  end

  // Decode presents a known opcode with every valid issue.
  a_issue_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_valid |-> !$isunknown(i_opcode));

endmodule

//--- design/int_alu.sv
/* Integer ALU.
   Produces the destination register value for all non-CSR operations. */

`timescale 1ns/1ps
`include "exu_config.svh"

module int_alu
  import exu_pkg::*;
(
  input  opcode_e              i_opcode,
  input  logic [`EXU_XLEN-1:0] i_op1,
  input  logic [`EXU_XLEN-1:0] i_op2,
  input  logic [`EXU_XLEN-1:0] i_op3,
  output logic [`EXU_XLEN-1:0] o_result
);

  localparam int SHW = $clog2(`EXU_XLEN);

  logic [`EXU_XLEN-1:0] sum;
  logic [`EXU_XLEN-1:0] diff;
  logic [SHW-1:0]       shamt;
  logic [4:0]           shamt_w;
  logic [31:0]          sll_w;
  logic [31:0]          srl_w;
  logic [31:0]          sra_w;
  logic                 lt;
  logic                 ltu;

  // W forms keep the low word and sign-extend it to the full width.
  function automatic logic [`EXU_XLEN-1:0] sext_w(input logic [31:0] val);
    return {{(`EXU_XLEN-32){val[31]}}, val};
  endfunction

  assign sum     = i_op1 + i_op2;
  assign diff    = i_op1 - i_op2;
  assign shamt   = i_op2[SHW-1:0];
  assign shamt_w = i_op2[4:0];
  assign sll_w   = i_op1[31:0] << shamt_w;
  assign srl_w   = i_op1[31:0] >> shamt_w;
  assign sra_w   = $signed(i_op1[31:0]) >>> shamt_w;
  assign lt      = $signed(i_op1) < $signed(i_op2);
  assign ltu     = i_op1 < i_op2;

  always_comb begin
    case (i_opcode)
      OP_ADD:   o_result = sum;
      OP_SUB:   o_result = diff;
      OP_ADDW:  o_result = sext_w(sum[31:0]);
      OP_SUBW:  o_result = sext_w(diff[31:0]);
      OP_AND:   o_result = i_op1 & i_op2;
      OP_OR:    o_result = i_op1 | i_op2;
      OP_XOR:   o_result = i_op1 ^ i_op2;
      OP_SLL:   o_result = i_op1 << shamt;
      OP_SRL:   o_result = i_op1 >> shamt;
      OP_SRA:   o_result = $signed(i_op1) >>> shamt;
      OP_SLLW:  o_result = sext_w(sll_w);
      OP_SRLW:  o_result = sext_w(srl_w);
      OP_SRAW:  o_result = sext_w(sra_w);
      OP_SLT:   o_result = {{(`EXU_XLEN-1){1'b0}}, lt};
      OP_SLTU:  o_result = {{(`EXU_XLEN-1){1'b0}}, ltu};
      // Decode has already shifted the upper immediate into place.
      OP_LUI:   o_result = i_op1;
      OP_AUIPC: o_result = sum;
      // Operand 3 carries the link address for jumps.
      OP_JAL:   o_result = i_op3;
      OP_JALR:  o_result = i_op3;
      default:  o_result = '0;
    endcase
  end

endmodule

//--- dv/exu_tb.sv
/* Execute stage testbench.
   Applies a table of operations, CSR accesses and APB transfers and checks each result. */

`timescale 1ns/1ps
`include "exu_config.svh"

module exu_tb
  import exu_pkg::*;
();

  localparam int RAND_ROWS   = 40;
  localparam int APB_TIMEOUT = 20;
  localparam int CYCLE_GAP   = 7;

  typedef struct packed {
    logic                 valid;
    opcode_e              op;
    logic [`EXU_XLEN-1:0] op1;
    logic [`EXU_XLEN-1:0] op2;
    logic [`EXU_XLEN-1:0] op3;
    logic [`EXU_XLEN-1:0] rd;
    logic                 jmp;
    logic [`EXU_XLEN-1:0] tgt;
    logic                 skip;
  } row_t;

  logic                   i_clk;
  logic                   i_rst_n;
  logic                   i_valid;
  opcode_e                i_opcode;
  logic [`EXU_XLEN-1:0]   i_op1;
  logic [`EXU_XLEN-1:0]   i_op2;
  logic [`EXU_XLEN-1:0]   i_op3;
  logic                   o_wb_valid;
  logic [`EXU_XLEN-1:0]   o_rd_wdata;
  logic                   o_pc_jmp;
  logic [`EXU_XLEN-1:0]   o_pc_jmpaddr;
  logic                   o_skip_cmt;
  logic                   i_psel;
  logic                   i_penable;
  logic                   i_pwrite;
  logic [`EXU_CSR_AW-1:0] i_paddr;
  logic [`EXU_XLEN-1:0]   i_pwdata;
  logic [`EXU_XLEN-1:0]   o_prdata;
  logic                   o_pready;

  row_t rows[$];
  int   errors = 0;
  int   checks = 0;

  exu_top exu_top_inst (.*);

  always #5 i_clk = ~i_clk;

  function automatic logic [`EXU_XLEN-1:0] sign_ext32(input logic [31:0] w);
    return {{(`EXU_XLEN-32){w[31]}}, w};
  endfunction

  // Reference register result, written from the ISA rules for each operation.
  function automatic logic [`EXU_XLEN-1:0] expected_rd(input opcode_e op,
      input logic [`EXU_XLEN-1:0] a, input logic [`EXU_XLEN-1:0] b,
      input logic [`EXU_XLEN-1:0] c);
    logic [`EXU_XLEN-1:0] res;
    res = '0;
    case (op)
      OP_ADD:   res = a + b;
      OP_SUB:   res = a - b;
      OP_ADDW:  res = sign_ext32(a[31:0] + b[31:0]);
      OP_SUBW:  res = sign_ext32(a[31:0] - b[31:0]);
      OP_AND:   res = a & b;
      OP_OR:    res = a | b;
      OP_XOR:   res = a ^ b;
      OP_SLL:   res = a << b[5:0];
      OP_SRL:   res = a >> b[5:0];
      OP_SRA:   res = $signed(a) >>> b[5:0];
      OP_SLLW:  res = sign_ext32(a[31:0] << b[4:0]);
      OP_SRLW:  res = sign_ext32(a[31:0] >> b[4:0]);
      OP_SRAW:  res = sign_ext32($signed(a[31:0]) >>> b[4:0]);
      OP_SLT:   res = ($signed(a) < $signed(b)) ? 1 : 0;
      OP_SLTU:  res = (a < b) ? 1 : 0;
      OP_LUI:   res = a;
      OP_AUIPC: res = a + b;
      OP_JAL:   res = c;
      OP_JALR:  res = c;
      default:  res = '0;
    endcase
    return res;
  endfunction

  function automatic void add_row(input logic valid, input opcode_e op,
      input logic [`EXU_XLEN-1:0] a, input logic [`EXU_XLEN-1:0] b,
      input logic [`EXU_XLEN-1:0] c, input logic [`EXU_XLEN-1:0] rd,
      input logic jmp, input logic [`EXU_XLEN-1:0] tgt, input logic skip);
    row_t r;
    r = '{valid, op, a, b, c, rd, jmp, tgt, skip};
    rows.push_back(r);
  endfunction

  function automatic void add_model_row(input opcode_e op, input logic [`EXU_XLEN-1:0] a,
      input logic [`EXU_XLEN-1:0] b, input logic [`EXU_XLEN-1:0] c);
    add_row(1'b1, op, a, b, c, expected_rd(op, a, b, c), 1'b0, '0, 1'b0);
  endfunction

  task automatic report_mismatch(input string msg);
    errors++;
    $display("Mismatch at %0t: %s", $time, msg);
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // Called 1 ns after a rising edge; returns 1 ns after the capturing edge.
  task automatic issue(input logic valid, input opcode_e op, input logic [`EXU_XLEN-1:0] a,
      input logic [`EXU_XLEN-1:0] b, input logic [`EXU_XLEN-1:0] c);
    i_valid  = valid;
    i_opcode = op;
    i_op1    = a;
    i_op2    = b;
    i_op3    = c;
    @(posedge i_clk);
    #1;
  endtask

  task automatic drive_idle();
    i_valid  = 1'b0;
    i_opcode = OP_NOP;
    i_op1    = '0;
    i_op2    = '0;
    i_op3    = '0;
  endtask

  task automatic check_row(input int idx, input row_t r);
    checks++;
    if (o_wb_valid !== r.valid)
      report_mismatch($sformatf("row %0d op %0d wb_valid %b, expected %b", idx, r.op,
                                o_wb_valid, r.valid));
    if (r.valid && o_rd_wdata !== r.rd)
      report_mismatch($sformatf("row %0d op %0d rd 0x%0h, expected 0x%0h", idx, r.op,
                                o_rd_wdata, r.rd));
    if (o_pc_jmp !== r.jmp)
      report_mismatch($sformatf("row %0d op %0d jump %b, expected %b", idx, r.op,
                                o_pc_jmp, r.jmp));
    if (r.jmp && o_pc_jmpaddr !== r.tgt)
      report_mismatch($sformatf("row %0d op %0d target 0x%0h, expected 0x%0h", idx, r.op,
                                o_pc_jmpaddr, r.tgt));
    if (o_skip_cmt !== r.skip)
      report_mismatch($sformatf("row %0d op %0d skip %b, expected %b", idx, r.op,
                                o_skip_cmt, r.skip));
  endtask

  // Samples mid-cycle and counts wait states until the access phase completes.
  task automatic wait_ready(output int waits);
    waits = 0;
    @(negedge i_clk);
    while (!o_pready && waits < APB_TIMEOUT) begin
      waits++;
      @(negedge i_clk);
    end
    if (!o_pready)
      abort_run($sformatf("APB transfer to 0x%0h never got ready", i_paddr));
  endtask

  task automatic apb_write(input logic [`EXU_CSR_AW-1:0] addr,
      input logic [`EXU_XLEN-1:0] data, output int waits);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = 1'b1;
    i_paddr   = addr;
    i_pwdata  = data;
    @(posedge i_clk);
    #1;
    i_penable = 1'b1;
    wait_ready(waits);
    @(posedge i_clk);
    #1;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [`EXU_CSR_AW-1:0] addr,
      output logic [`EXU_XLEN-1:0] data, output int waits);
    i_psel    = 1'b1;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = addr;
    @(posedge i_clk);
    #1;
    i_penable = 1'b1;
    wait_ready(waits);
    data = o_prdata;
    @(posedge i_clk);
    #1;
    i_psel    = 1'b0;
    i_penable = 1'b0;
  endtask

  task automatic compare_value(input string what, input logic [`EXU_XLEN-1:0] got,
      input logic [`EXU_XLEN-1:0] exp);
    checks++;
    if (got !== exp)
      report_mismatch($sformatf("%s is 0x%0h, expected 0x%0h", what, got, exp));
  endtask

  initial begin
    logic [`EXU_XLEN-1:0] a;
    logic [`EXU_XLEN-1:0] b;
    logic [`EXU_XLEN-1:0] c;
    logic [`EXU_XLEN-1:0] data;
    logic [`EXU_XLEN-1:0] cyc_first;
    opcode_e              op;
    int                   waits;

    i_clk     = 1'b0;
    i_rst_n   = 1'b0;
    i_psel    = 1'b0;
    i_penable = 1'b0;
    i_pwrite  = 1'b0;
    i_paddr   = '0;
    i_pwdata  = '0;
    drive_idle();
    void'($urandom(32'h84d3));

    repeat (5) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    checks++;
    if (o_wb_valid !== 1'b0 || o_pc_jmp !== 1'b0 || o_skip_cmt !== 1'b0 || o_pready !== 1'b0)
      report_mismatch("control outputs not low after reset");
    apb_read(`EXU_CSR_MSTATUS, data, waits);
    compare_value("mstatus after reset", data, '0);
    compare_value("wait states on idle APB read", waits, 0);

    // Corner cases: overflow, 63-bit shifts and negative operands.
    add_model_row(OP_ADD, 64'h7fff_ffff_ffff_ffff, 64'd1, '0);
    add_model_row(OP_SUB, 64'd0, 64'd1, '0);
    add_model_row(OP_ADDW, 64'h0000_0000_7fff_ffff, 64'd1, '0);
    add_model_row(OP_SUBW, 64'd0, 64'd1, '0);
    add_model_row(OP_AND, 64'hf0f0_1234_ffff_0000, 64'h0ff0_ffff_00ff_ff00, '0);
    add_model_row(OP_OR, 64'hf0f0_1234_ffff_0000, 64'h0ff0_ffff_00ff_ff00, '0);
    add_model_row(OP_XOR, 64'hf0f0_1234_ffff_0000, 64'h0ff0_ffff_00ff_ff00, '0);
    add_model_row(OP_SLL, 64'd1, 64'd63, '0);
    add_model_row(OP_SRL, '1, 64'd63, '0);
    add_model_row(OP_SRA, 64'h8000_0000_0000_0000, 64'd63, '0);
    add_model_row(OP_SLLW, 64'd1, 64'd31, '0);
    add_model_row(OP_SRLW, '1, 64'd31, '0);
    add_model_row(OP_SRAW, 64'h0000_0000_8000_0000, 64'd31, '0);
    add_model_row(OP_SLT, '1, 64'd1, '0);
    add_model_row(OP_SLTU, '1, 64'd1, '0);
    add_model_row(OP_LUI, 64'h0000_0000_1234_5000, '0, '0);
    add_model_row(OP_AUIPC, 64'h0000_0000_0000_1000, 64'h0000_0000_4000_0000, '0);
    add_model_row(OP_NOP, 64'd5, 64'd6, 64'd7);
    for (int i = 0; i < RAND_ROWS; i++) begin
      op = opcode_e'(1 + $urandom_range(16));
      a  = {$urandom, $urandom};
      b  = {$urandom, $urandom};
      c  = {$urandom, $urandom};
      add_model_row(op, a, b, c);
    end

    // Each compare taken and not taken, then the two jumps.
    add_row(1, OP_BEQ, 64'd5, 64'd5, 64'h1000, '0, 1, 64'h1000, 0);
    add_row(1, OP_BEQ, 64'd5, 64'd6, 64'h1000, '0, 0, '0, 0);
    add_row(1, OP_BNE, 64'd5, 64'd6, 64'h1100, '0, 1, 64'h1100, 0);
    add_row(1, OP_BNE, 64'd7, 64'd7, 64'h1100, '0, 0, '0, 0);
    add_row(1, OP_BLT, '1, 64'd1, 64'h1200, '0, 1, 64'h1200, 0);
    add_row(1, OP_BLT, 64'd1, '1, 64'h1200, '0, 0, '0, 0);
    add_row(1, OP_BGE, 64'd1, '1, 64'h1300, '0, 1, 64'h1300, 0);
    add_row(1, OP_BGE, 64'hffff_ffff_ffff_fffe, '1, 64'h1300, '0, 0, '0, 0);
    add_row(1, OP_BLTU, 64'd1, '1, 64'h1400, '0, 1, 64'h1400, 0);
    add_row(1, OP_BLTU, '1, 64'd1, 64'h1400, '0, 0, '0, 0);
    add_row(1, OP_BGEU, '1, 64'd1, 64'h1500, '0, 1, 64'h1500, 0);
    add_row(1, OP_BGEU, 64'd0, 64'd1, 64'h1500, '0, 0, '0, 0);
    add_row(1, OP_JAL, '0, '0, 64'h2004, 64'h2004, 1, 64'h2004, 0);
    add_row(1, OP_JALR, 64'h3001, 64'h10, 64'h2008, 64'h2008, 1, 64'h3010, 0);
    // Idle slots, even with a jump opcode on the bus.
    add_row(0, OP_JAL, '0, '0, 64'h2004, '0, 0, '0, 0);
    add_row(0, OP_ADD, 64'd1, 64'd2, '0, '0, 0, '0, 0);

    // mscratch read-modify-write; each access returns the previous value.
    add_row(1, OP_CSRRW, 64'h1234_5678_9abc_def0, `EXU_CSR_MSCRATCH, '0, '0, 0, '0, 0);
    add_row(1, OP_CSRRS, 64'h0f, `EXU_CSR_MSCRATCH, '0, 64'h1234_5678_9abc_def0, 0, '0, 0);
    add_row(1, OP_CSRRC, 64'hf0, `EXU_CSR_MSCRATCH, '0, 64'h1234_5678_9abc_deff, 0, '0, 0);
    add_row(1, OP_CSRRS, '0, `EXU_CSR_MSTATUS, '0, '0, 0, '0, 0);

    foreach (rows[i]) begin
      issue(rows[i].valid, rows[i].op, rows[i].op1, rows[i].op2, rows[i].op3);
      check_row(i, rows[i]);
    end
    drive_idle();

    apb_read(`EXU_CSR_MSCRATCH, data, waits);
    compare_value("mscratch after CSRRW, CSRRS, CSRRC", data, 64'h1234_5678_9abc_de0f);

    // Two mcycle reads CYCLE_GAP + 1 edges apart.
    issue(1'b1, OP_CSRRS, '0, `EXU_CSR_MCYCLE, '0);
    cyc_first = o_rd_wdata;
    compare_value("skip commit on first mcycle read", o_skip_cmt, 1);
    drive_idle();
    repeat (CYCLE_GAP) @(posedge i_clk);
    #1;
    issue(1'b1, OP_CSRRS, '0, `EXU_CSR_MCYCLE, '0);
    compare_value("mcycle difference", o_rd_wdata - cyc_first, CYCLE_GAP + 1);
    compare_value("skip commit on second mcycle read", o_skip_cmt, 1);
    drive_idle();

    // Host write to mepc collides with an instruction write in the access phase.
    fork
      apb_write(`EXU_CSR_MEPC, 64'hcafe_0000_0000_1230, waits);
      begin
        @(posedge i_clk);
        #1;
        issue(1'b1, OP_CSRRW, 64'h0000_0000_0000_4440, `EXU_CSR_MEPC, '0);
        compare_value("old mepc from colliding CSRRW", o_rd_wdata, '0);
        drive_idle();
      end
    join
    compare_value("wait states on colliding APB write", waits, 1);
    apb_read(`EXU_CSR_MEPC, data, waits);
    compare_value("mepc after collision", data, 64'hcafe_0000_0000_1230);

    issue(1'b0, OP_NOP, '0, '0, '0);
    checks++;
    if (o_wb_valid !== 1'b0 || o_pc_jmp !== 1'b0)
      report_mismatch("idle cycle raised valid or jump");

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("RESULT: PASS");
    else
      $display("RESULT: FAIL");
    $finish;
  end

endmodule

//--- tb.f
+incdir+common
common/exu_pkg.sv
design/int_alu.sv
design/branch_unit.sv
csr_file/csr_file.sv
design/exu_writeback.sv
design/exu_top.sv
dv/exu_tb.sv
